/* rtl/riscv_defs.svh */
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

// Datapath and register file geometry
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// Fetch start and the no-op used for annulled slots
`define RESET_PC     32'h0000_0000
`define BUBBLE_INSTR 32'h0000_0013

`endif

/* rtl/riscv_pkg.sv */
`include "riscv_defs.svh"

package riscv_pkg;

    // Major opcodes of the decoded subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_op_e;

    // Next-PC source, resolved in EX
    typedef enum logic [1:0] {
        PC_NEXT, PC_BRANCH, PC_JUMP_IMM, PC_JUMP_ALU
    } pc_sel_e;

    // All-zero value of this bundle is a bubble
    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       a;
        logic [`XLEN-1:0]       b;
        logic [`XLEN-1:0]       target;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   werf;
        alu_op_e                alu_op;
        br_op_e                 br_op;
        pc_sel_e                pc_sel;
    } issue_t;

endpackage

/* rtl/bypass_if.sv */
`timescale 1ns/100ps
`include "riscv_defs.svh"

// Final result of each stage past ID, for forwarding and write-back
interface bypass_if;
    logic [`REG_ADDR_W-1:0] ex_rd;
    logic                   ex_werf;
    logic [`XLEN-1:0]       ex_value;
    logic [`REG_ADDR_W-1:0] mem_rd;
    logic                   mem_werf;
    logic [`XLEN-1:0]       mem_value;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic                   wb_werf;
    logic [`XLEN-1:0]       wb_value;

    modport producer (output ex_rd, ex_werf, ex_value, mem_rd, mem_werf, mem_value,
                      wb_rd, wb_werf, wb_value);
    modport consumer (input ex_rd, ex_werf, ex_value, mem_rd, mem_werf, mem_value,
                      wb_rd, wb_werf, wb_value);

    // WB group doubles as the register file write port
    modport writer (input wb_rd, wb_werf, wb_value);
endinterface

/* rtl/fetch_unit.sv */
`timescale 1ns/100ps
`include "riscv_defs.svh"

module fetch_unit (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             cpu_step_in,
    input  logic             annul,
    input  logic [`XLEN-1:0] target,
    input  logic [`XLEN-1:0] imem_data_in,
    output logic [`XLEN-1:0] imem_addr_out,
    output logic [`XLEN-1:0] id_pc,
    output logic [`XLEN-1:0] id_instr
);
    // PC is the fetch address itself
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            imem_addr_out <= `RESET_PC;
        end else if (cpu_step_in) begin
            imem_addr_out <= annul ? target : imem_addr_out + `XLEN'd4;
        end
    end

    // IF/ID register, squashed to a no-op on redirect
    always_ff @(posedge clk_in) begin
        if (rst_in || (cpu_step_in && annul)) begin
            id_pc    <= '0;
            id_instr <= `BUBBLE_INSTR;
        end else if (cpu_step_in) begin
            id_pc    <= imem_addr_out;
            id_instr <= imem_data_in;
        end
    end
endmodule

/* rtl/issue_stage.sv */
`timescale 1ns/100ps
`include "riscv_defs.svh"

module issue_stage import riscv_pkg::*; (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   cpu_step_in,
    input  logic                   annul,
    input  logic [`XLEN-1:0]       id_pc,
    input  logic [`XLEN-1:0]       id_instr,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    bypass_if.consumer             byp,
    output issue_t                 issue
);
    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [`XLEN-1:0] imm_i, imm_u, imm_b, imm_j;
    logic [`XLEN-1:0] imm, tgt_imm;
    logic             valid, werf, use_rs1, use_rs2, a_is_pc, b_is_imm;
    alu_op_e          alu_op;
    br_op_e           br_op;
    pc_sel_e          pc_sel;
    logic [`XLEN-1:0] rs1_val, rs2_val;

    // funct3 to ALU operation, alt selects sub or sra
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Youngest writer wins
    function automatic logic [`XLEN-1:0] forward(input logic [`REG_ADDR_W-1:0] rs,
                                                 input logic used,
                                                 input logic [`XLEN-1:0] rf_value);
        if (!used || rs == '0) return rf_value;
        if (byp.ex_werf && byp.ex_rd == rs) return byp.ex_value;
        if (byp.mem_werf && byp.mem_rd == rs) return byp.mem_value;
        if (byp.wb_werf && byp.wb_rd == rs) return byp.wb_value;
        return rf_value;
    endfunction

    assign opcode = opcode_e'(id_instr[6:0]);
    assign funct3 = id_instr[14:12];
    assign rs1    = id_instr[19:15];
    assign rs2    = id_instr[24:20];

    assign imm_i = {{20{id_instr[31]}}, id_instr[31:20]};
    assign imm_u = {id_instr[31:12], 12'b0};
    assign imm_b = {{20{id_instr[31]}}, id_instr[7], id_instr[30:25], id_instr[11:8], 1'b0};
    assign imm_j = {{12{id_instr[31]}}, id_instr[19:12], id_instr[20], id_instr[30:21], 1'b0};

    ////////////////////
    // Decode
    always_comb begin
        valid    = 1'b1;
        werf     = 1'b1;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        a_is_pc  = 1'b0;
        b_is_imm = 1'b1;
        imm      = imm_i;
        tgt_imm  = imm_b;
        alu_op   = ALU_ADD;
        br_op    = BR_NONE;
        pc_sel   = PC_NEXT;
        case (opcode)
            OPC_OP: begin
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                b_is_imm = 1'b0;
                alu_op   = alu_decode(funct3, id_instr[30]);
            end
            OPC_OP_IMM: begin
                use_rs1 = 1'b1;
                alu_op  = alu_decode(funct3, funct3 == 3'b101 && id_instr[30]);
            end
            OPC_LUI: begin
                imm    = imm_u;
                alu_op = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                a_is_pc = 1'b1;
                imm     = imm_u;
            end
            OPC_JAL: begin
                tgt_imm = imm_j;
                pc_sel  = PC_JUMP_IMM;
            end
            OPC_JALR: begin
                use_rs1 = 1'b1;
                pc_sel  = PC_JUMP_ALU;
            end
            OPC_BRANCH: begin
                werf     = 1'b0;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                b_is_imm = 1'b0;
                pc_sel   = PC_BRANCH;
                case (funct3)
                    3'b000:  br_op = BR_EQ;
                    3'b001:  br_op = BR_NE;
                    3'b100:  br_op = BR_LT;
                    3'b101:  br_op = BR_GE;
                    3'b110:  br_op = BR_LTU;
                    3'b111:  br_op = BR_GEU;
                    default: valid = 1'b0;
                endcase
            end
            // Fence, system and anything else
            default: valid = 1'b0;
        endcase
    end

    ////////////////////
    // Operands
    always_comb begin
        rs1_val = forward(rs1, use_rs1, rs1_data);
        rs2_val = forward(rs2, use_rs2, rs2_data);
    end

    ////////////////////
    // ID/EX register
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            issue <= '0;
        end else if (cpu_step_in) begin
            if (annul || !valid) begin
                issue <= '0;
            end else begin
                issue.pc     <= id_pc;
                issue.a      <= a_is_pc ? id_pc : rs1_val;
                issue.b      <= b_is_imm ? imm : rs2_val;
                issue.target <= id_pc + tgt_imm;
                issue.rd     <= id_instr[11:7];
                issue.werf   <= werf;
                issue.alu_op <= alu_op;
                issue.br_op  <= br_op;
                issue.pc_sel <= pc_sel;
            end
        end
    end
endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/100ps
`include "riscv_defs.svh"

module execute_stage import riscv_pkg::*; (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             cpu_step_in,
    input  issue_t           issue,
    output logic             annul,
    output logic [`XLEN-1:0] target,
    bypass_if.producer       byp
);
    logic [`XLEN-1:0] alu_result;
    logic             br_taken;
    logic             is_jump;

    always_comb begin
        case (issue.alu_op)
            ALU_SUB:    alu_result = issue.a - issue.b;
            ALU_AND:    alu_result = issue.a & issue.b;
            ALU_OR:     alu_result = issue.a | issue.b;
            ALU_XOR:    alu_result = issue.a ^ issue.b;
            ALU_SLL:    alu_result = issue.a << issue.b[4:0];
            ALU_SRL:    alu_result = issue.a >> issue.b[4:0];
            ALU_SRA:    alu_result = $signed(issue.a) >>> issue.b[4:0];
            ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, $signed(issue.a) < $signed(issue.b)};
            ALU_SLTU:   alu_result = {{(`XLEN-1){1'b0}}, issue.a < issue.b};
            ALU_PASS_B: alu_result = issue.b;
            default:    alu_result = issue.a + issue.b;
        endcase
    end

    always_comb begin
        case (issue.br_op)
            BR_EQ:   br_taken = issue.a == issue.b;
            BR_NE:   br_taken = issue.a != issue.b;
            BR_LT:   br_taken = $signed(issue.a) < $signed(issue.b);
            BR_GE:   br_taken = $signed(issue.a) >= $signed(issue.b);
            BR_LTU:  br_taken = issue.a < issue.b;
            BR_GEU:  br_taken = issue.a >= issue.b;
            default: br_taken = 1'b0;
        endcase
    end

    // Redirect, JALR drops bit 0 of its sum
    assign is_jump = issue.pc_sel == PC_JUMP_IMM || issue.pc_sel == PC_JUMP_ALU;
    assign annul   = is_jump || (issue.pc_sel == PC_BRANCH && br_taken);
    assign target  = (issue.pc_sel == PC_JUMP_ALU) ? {alu_result[`XLEN-1:1], 1'b0}
                                                   : issue.target;

    // Jumps write their link address
    assign byp.ex_rd    = issue.rd;
    assign byp.ex_werf  = issue.werf;
    assign byp.ex_value = is_jump ? issue.pc + `XLEN'd4 : alu_result;

    ////////////////////
    // MEM and WB registers
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            byp.mem_werf <= 1'b0;
            byp.wb_werf  <= 1'b0;
        end else if (cpu_step_in) begin
            byp.mem_werf <= byp.ex_werf;
            byp.wb_werf  <= byp.mem_werf;
        end
    end

    always_ff @(posedge clk_in) begin
        if (cpu_step_in) begin
            byp.mem_rd    <= byp.ex_rd;
            byp.mem_value <= byp.ex_value;
            byp.wb_rd     <= byp.mem_rd;
            byp.wb_value  <= byp.mem_value;
        end
    end
endmodule

/* rtl/regfile.sv */
`timescale 1ns/100ps
`include "riscv_defs.svh"

module regfile (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   cpu_step_in,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data,
    bypass_if.writer               wr,
    input  logic [`REG_ADDR_W-1:0] debug_reg_in,
    output logic [`XLEN-1:0]       debug_reg_out
);
    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_ADDR_W-1:0] idx);
        return (idx == '0) ? '0 : regs[idx];
    endfunction

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (cpu_step_in && wr.wb_werf && wr.wb_rd != '0) begin
            regs[wr.wb_rd] <= wr.wb_value;
        end
    end

    // Same-cycle writes reach ID through WB forwarding
    always_comb begin
        rs1_data      = read_reg(rs1);
        rs2_data      = read_reg(rs2);
        debug_reg_out = read_reg(debug_reg_in);
    end
endmodule

/* rtl/riscv_core.sv */
`timescale 1ns/100ps
`include "riscv_defs.svh"

module riscv_core import riscv_pkg::*; (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   cpu_step_in,
    input  logic [`XLEN-1:0]       imem_data_in,
    output logic [`XLEN-1:0]       imem_addr_out,
    input  logic [`REG_ADDR_W-1:0] debug_reg_in,
    output logic [`XLEN-1:0]       debug_reg_out
);
    logic [`XLEN-1:0]       id_pc;
    logic [`XLEN-1:0]       id_instr;
    logic [`REG_ADDR_W-1:0] rs1, rs2;
    logic [`XLEN-1:0]       rs1_data, rs2_data;
    issue_t                 issue;
    logic                   annul;
    logic [`XLEN-1:0]       target;

    bypass_if byp ();

    ////////////////////
    // Pipeline stages
    fetch_unit fetch (
        .clk_in(clk_in), .rst_in(rst_in), .cpu_step_in(cpu_step_in),
        .annul(annul), .target(target),
        .imem_data_in(imem_data_in), .imem_addr_out(imem_addr_out),
        .id_pc(id_pc), .id_instr(id_instr)
    );

    issue_stage issue_unit (
        .clk_in(clk_in), .rst_in(rst_in), .cpu_step_in(cpu_step_in),
        .annul(annul), .id_pc(id_pc), .id_instr(id_instr),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .byp(byp.consumer), .issue(issue)
    );

    execute_stage execute (
        .clk_in(clk_in), .rst_in(rst_in), .cpu_step_in(cpu_step_in),
        .issue(issue), .annul(annul), .target(target),
        .byp(byp.producer)
    );

    // Register file, written from the WB group
    regfile rf (
        .clk_in(clk_in), .rst_in(rst_in), .cpu_step_in(cpu_step_in),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr(byp.writer),
        .debug_reg_in(debug_reg_in), .debug_reg_out(debug_reg_out)
    );
endmodule

/* testbench/riscv_core_asserts.sv */
`timescale 1ns/100ps
`include "riscv_defs.svh"

module riscv_core_asserts (
    input logic                   clk_in,
    input logic                   rst_in,
    input logic                   cpu_step_in,
    input logic [`XLEN-1:0]       imem_addr_out,
    input logic [`REG_ADDR_W-1:0] debug_reg_in,
    input logic [`XLEN-1:0]       debug_reg_out
);
    ////////////////////
    // Fetch address rules
    addr_aligned: assert property (@(posedge clk_in) disable iff (rst_in)
        imem_addr_out[1:0] == 2'b00)
        else $error("imem_addr_out is not word aligned");

    addr_after_reset: assert property (@(posedge clk_in)
        rst_in |=> imem_addr_out == `RESET_PC)
        else $error("imem_addr_out is not the reset PC after reset");

    // Frozen pipeline keeps its fetch address
    addr_frozen: assert property (@(posedge clk_in)
        (!rst_in && !cpu_step_in) |=> $stable(imem_addr_out))
        else $error("imem_addr_out moved while cpu_step_in was low");

    ////////////////////
    // Register zero
    x0_reads_zero: assert property (@(posedge clk_in)
        debug_reg_in == '0 |-> debug_reg_out == '0)
        else $error("debug port read a nonzero x0");
endmodule

bind riscv_core riscv_core_asserts core_checks (
    .clk_in(clk_in), .rst_in(rst_in), .cpu_step_in(cpu_step_in),
    .imem_addr_out(imem_addr_out),
    .debug_reg_in(debug_reg_in), .debug_reg_out(debug_reg_out)
);

/* testbench/tb_riscv_core.sv */
`timescale 1ns/100ps
`include "riscv_defs.svh"

module tb_riscv_core;
    localparam int PROG_WORDS     = 24;
    localparam int EXPECT_BASE    = 24;
    localparam int CHECKED_REGS   = 16;
    localparam int HALT_WORD      = 40;
    localparam int DATA_WORDS     = 41;
    localparam int EARLY_STEPS    = 3;
    localparam int RUN_STEPS      = 3 * PROG_WORDS;
    // About four cycles per step, two per register read, plus margin
    localparam int TIMEOUT_CYCLES = RUN_STEPS * 4 + CHECKED_REGS * 2 + 80;
    localparam logic [31:0] PROG_BYTES = 32'(PROG_WORDS * 4);
    localparam logic [31:0] LCG_SEED   = 32'h3515;

    logic                   clk_in;
    logic                   rst_in;
    logic                   cpu_step_in;
    logic [`XLEN-1:0]       imem_data_in;
    logic [`XLEN-1:0]       imem_addr_out;
    logic [`REG_ADDR_W-1:0] debug_reg_in;
    logic [`XLEN-1:0]       debug_reg_out;

    logic [31:0] testdata [0:DATA_WORDS-1];
    logic [5:0]  fetch_word;
    logic        in_program;
    logic [31:0] expect_addr;
    logic [31:0] halt_addr;
    logic [31:0] halt_slot;
    logic [31:0] lcg_state   = LCG_SEED;
    int          step_count  = 0;
    int          error_count = 0;
    int          cycle_count = 0;

    riscv_core DUT (
        .clk_in(clk_in), .rst_in(rst_in), .cpu_step_in(cpu_step_in),
        .imem_data_in(imem_data_in), .imem_addr_out(imem_addr_out),
        .debug_reg_in(debug_reg_in), .debug_reg_out(debug_reg_out)
    );

    // Instruction memory answers in the same cycle, no-ops past the program
    assign in_program   = imem_addr_out < PROG_BYTES;
    assign fetch_word   = imem_addr_out[7:2];
    assign imem_data_in = in_program ? testdata[fetch_word] : `BUBBLE_INSTR;

    always #50 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d errors", cycle_count, error_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, expected);
            error_count++;
        end
    endtask

    initial begin
        clk_in       = 1'b0;
        rst_in       = 1'b1;
        cpu_step_in  = 1'b0;
        debug_reg_in = '0;
        $readmemh("testbench/riscv_core_testdata.hex", testdata);

        repeat (2) @(posedge clk_in);
        #10;
        rst_in = 1'b0;
        check_value("imem_addr_out", imem_addr_out, `RESET_PC);
        expect_addr = `RESET_PC;

        ////////////////////
        // Random stepping, first edge frozen
        while (step_count < RUN_STEPS) begin
            @(posedge clk_in);
            #10;
            // Sequential fetch before any redirect can resolve
            if (step_count < EARLY_STEPS) begin
                if (cpu_step_in) begin
                    expect_addr = expect_addr + 32'd4;
                end
                check_value("imem_addr_out", imem_addr_out, expect_addr);
            end
            if (cpu_step_in) begin
                step_count++;
            end
            lcg_state   = lcg_next(lcg_state);
            cpu_step_in = lcg_state[31:30] != 2'b00;
        end
        cpu_step_in = 1'b0;

        ////////////////////
        // Register results through the debug port
        for (int r = 0; r < CHECKED_REGS; r++) begin
            @(posedge clk_in);
            #10;
            debug_reg_in = 5'(r);
            @(negedge clk_in);
            check_value($sformatf("debug_reg_out[x%0d]", r), debug_reg_out,
                        testdata[6'(EXPECT_BASE + r)]);
        end

        // Self-loop may sit in its annul shadow
        halt_addr = testdata[HALT_WORD];
        halt_slot = imem_addr_out - halt_addr;
        if (halt_slot != 32'd4 && halt_slot != 32'd8) begin
            check_value("imem_addr_out", imem_addr_out, halt_addr);
        end

        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end
endmodule

/* riscv_core.f */
+incdir+rtl
rtl/riscv_pkg.sv
rtl/bypass_if.sv
rtl/fetch_unit.sv
rtl/issue_stage.sv
rtl/execute_stage.sv
rtl/regfile.sv
rtl/riscv_core.sv
testbench/riscv_core_asserts.sv
testbench/tb_riscv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the riscv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

if ! verilator --binary --timing --assert -j 0 \
        --top-module tb_riscv_core -Mdir "$OBJ_DIR" -o tb_riscv_core \
        -f riscv_core.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$OBJ_DIR/tb_riscv_core" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -q "^=== PASS ===$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* testbench/riscv_core_testdata.hex */
// Words 0-23 program, 24-39 expected x0-x15, 40 halt address
// One 32-bit hex word per line, instruction or value noted after it
00500093  // 00: addi  x1, x0, 5
00309113  // 04: slli  x2, x1, 3
401101b3  // 08: sub   x3, x2, x1
fff0c213  // 0c: xori  x4, x1, -1
401252b3  // 10: sra   x5, x4, x1
00125333  // 14: srl   x6, x4, x1
001223b3  // 18: slt   x7, x4, x1
00123433  // 1c: sltu  x8, x4, x1
123454b7  // 20: lui   x9, 0x12345
0034e533  // 24: or    x10, x9, x3
00040663  // 28: beq   x8, x0, +12 taken
fff00093  // 2c: addi  x1, x0, -1 sentinel
fff00113  // 30: addi  x2, x0, -1 sentinel
0040c463  // 34: blt   x1, x4, +8 not taken
0f057593  // 38: andi  x11, x10, 0xf0
0040f463  // 3c: bgeu  x1, x4, +8 not taken
0002a613  // 40: slti  x12, x5, 0
00c006ef  // 44: jal   x13, +12
fff00193  // 48: addi  x3, x0, -1 sentinel
fff00213  // 4c: addi  x4, x0, -1 sentinel
00000717  // 50: auipc x14, 0
00d707e7  // 54: jalr  x15, 13(x14)
fff00313  // 58: addi  x6, x0, -1 sentinel
0000006f  // 5c: jal   x0, 0 halt
00000000  // x0
00000005  // x1
00000028  // x2
00000023  // x3
fffffffa  // x4
ffffffff  // x5
07ffffff  // x6
00000001  // x7
00000000  // x8
12345000  // x9
12345023  // x10
00000020  // x11
00000001  // x12
00000048  // x13
00000050  // x14
00000058  // x15
0000005c  // halt address
